/* gesture_input.txt */
// Columns: features 0 to 15 as signed 8-bit hex, then the expected one-hot result
// Class c weighs feature i by +3 when i mod 4 equals c and by -1 otherwise
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 01
10 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 01
00 20 00 00 00 00 00 00 00 00 00 00 00 00 00 00 02
00 00 7F 00 00 00 7F 00 00 00 00 00 00 00 00 00 04
00 00 00 05 00 00 00 05 00 00 00 05 00 00 00 05 08
80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 01
00 10 10 00 00 00 00 00 00 00 00 00 00 00 00 00 02
00 00 08 08 00 00 00 00 00 00 00 00 00 00 00 00 04
80 FF FE FD 00 00 00 00 00 00 00 00 00 00 00 00 02
7F 7F 7F 7F 7F 7F 7F 7F 7F 7F 7F 7F 7F 7F 7F 7F 01
01 02 03 04 05 06 07 08 09 0A 0B 0C 0D 0E 0F 10 08
10 0F 0E 0D 0C 0B 0A 09 08 07 06 05 04 03 02 01 01
10 30 00 20 00 F0 00 00 00 00 00 00 00 00 00 00 02
80 01 03 02 80 00 00 FF 00 00 00 00 00 00 00 00 04

/* tb.f */
cnn_pkg.sv
gesture_scorer.sv
class_select.sv
ahb_cnn.sv
gesture_ahb_top.sv
tb_clock_gen.sv
tb_gesture_ahb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_gesture_ahb
LOG       ?= sim.log
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary -Wno-fatal

SOURCES := $(filter-out +incdir%,$(shell cat $(FILELIST)))
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(SIM) gesture_input.txt
	./$(SIM) > $(LOG) 2>&1 || true
	cat $(LOG)
	@grep -qF '*** TEST PASSED ***' $(LOG) && echo "Simulation passed" || \
		(echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tb_gesture_ahb.sv */
////////////////////
// Gesture classifier testbench with
// file-driven frames and AHB reads
////////////////////
`timescale 1ns/1ps

module tb_gesture_ahb import cnn_pkg::*; ();

    localparam int        N_FEATURES  = 16;
    localparam int        N_FRAMES    = 14;
    localparam int        WORDS       = N_FEATURES + 1;   // Features then expected one-hot
    localparam int        CYCLE_LIMIT = N_FRAMES * (N_FEATURES * 4 + 20) + 100;
    localparam ahb_addr_t RESULT_OFS  = 32'h0000_0000;
    localparam ahb_addr_t COUNT_OFS   = 32'h0000_0004;

    logic          HCLK;
    logic          HRESETn;
    logic          HSEL;
    ahb_addr_t     HADDR;
    logic [1:0]    HTRANS;
    logic [2:0]    HSIZE;
    logic [3:0]    HPROT;
    logic          HWRITE;
    ahb_data_t     HWDATA;
    logic          HREADY;
    logic          HREADYOUT;
    ahb_data_t     HRDATA;
    logic          HRESP;
    feature_beat_t beat;

    logic [7:0]    stim_mem [0:N_FRAMES*WORDS-1];
    logic [31:0]   lfsr_state = 32'd74014;
    frame_cnt_t    frames_sent;
    int            cycles = 0;

    tb_clock_gen u_clock_gen (
        .HCLK    (HCLK),
        .HRESETn (HRESETn)
    );

    gesture_ahb_top #(
        .N_FEATURES (N_FEATURES)
    ) u_gesture_ahb_top (
        .HCLK      (HCLK),
        .HRESETn   (HRESETn),
        .HSEL      (HSEL),
        .HADDR     (HADDR),
        .HTRANS    (HTRANS),
        .HSIZE     (HSIZE),
        .HPROT     (HPROT),
        .HWRITE    (HWRITE),
        .HWDATA    (HWDATA),
        .HREADY    (HREADY),
        .HREADYOUT (HREADYOUT),
        .HRDATA    (HRDATA),
        .HRESP     (HRESP),
        .beat      (beat)
    );

    task automatic stop_failed(input string what);
        $display("%s", what);
        $display("*** TEST FAILED ***");
        $fatal(1, "stopped at the first failure");
    endtask

    task automatic report_mismatch(input string name, input ahb_data_t got, input ahb_data_t exp);
        stop_failed($sformatf("Error at time %0t: %s got 0x%0h expected 0x%0h",
                              $time, name, got, exp));
    endtask

    task automatic check_result(input string name, input one_hot_t got, input one_hot_t exp);
        if (got !== exp) begin
            report_mismatch(name, ahb_data_t'(got), ahb_data_t'(exp));
        end
    endtask

    task automatic check_count(input string name, input frame_cnt_t got, input frame_cnt_t exp);
        if (got !== exp) begin
            report_mismatch(name, ahb_data_t'(got), ahb_data_t'(exp));
        end
    endtask

    task automatic check_data(input string name, input ahb_data_t got, input ahb_data_t exp);
        if (got !== exp) begin
            report_mismatch(name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            report_mismatch(name, ahb_data_t'(got), ahb_data_t'(exp));
        end
    endtask

    // Galois LFSR, one step per bit handed out
    function automatic logic [31:0] rand_bits(input int n);
        logic        lsb;
        logic [31:0] val;
        val = '0;
        for (int b = 0; b < n; b++) begin
            lsb        = lfsr_state[0];
            lfsr_state = lfsr_state >> 1;
            if (lsb) begin
                lfsr_state = lfsr_state ^ 32'h8020_0003;
            end
            val = {val[30:0], lsb};
        end
        return val;
    endfunction

    // Reference classifier built straight from the weight rule
    function automatic one_hot_t classify(input int frame);
        int score [4];
        int weight;
        int best;
        for (int c = 0; c < 4; c++) begin
            score[c] = 0;
            for (int i = 0; i < N_FEATURES; i++) begin
                weight   = ((i % 4) == c) ? 3 : -1;
                score[c] += int'($signed(stim_mem[frame*WORDS+i])) * weight;
            end
        end
        best = 0;
        for (int c = 1; c < 4; c++) begin
            if (score[c] > score[best]) begin
                best = c;                       // Lowest index keeps a tie
            end
        end
        return one_hot_t'(4'b0001 << best);
    endfunction

    task automatic ahb_read(input ahb_addr_t addr, output ahb_data_t data);
        @(negedge HCLK);
        HSEL   = 1'b1;
        HADDR  = addr;
        HTRANS = 2'b10;                         // NONSEQ
        HWRITE = 1'b0;
        @(negedge HCLK);
        HSEL   = 1'b0;
        HTRANS = 2'b00;
        data   = HRDATA;                        // Data phase
    endtask

    task automatic ahb_write(input ahb_addr_t addr, input ahb_data_t data);
        @(negedge HCLK);
        HSEL   = 1'b1;
        HADDR  = addr;
        HTRANS = 2'b10;
        HWRITE = 1'b1;
        @(negedge HCLK);
        HSEL   = 1'b0;
        HTRANS = 2'b00;
        HWRITE = 1'b0;
        HWDATA = data;
    endtask

    task automatic send_frame(input int frame, input bit gaps);
        logic [31:0] idle;
        for (int i = 0; i < N_FEATURES; i++) begin
            if (gaps) begin
                idle = rand_bits(2);            // 0 to 3 idle cycles
                repeat (idle) begin
                    @(negedge HCLK);
                    beat.valid = 1'b0;
                end
            end
            @(negedge HCLK);
            beat.valid = 1'b1;
            beat.data  = feature_t'(stim_mem[frame*WORDS+i]);
        end
    endtask

    task automatic end_stream();
        @(negedge HCLK);
        beat.valid = 1'b0;
    endtask

    task automatic check_frame(input int frame);
        ahb_data_t rd;
        one_hot_t  file_exp;
        file_exp = one_hot_t'(stim_mem[frame*WORDS+N_FEATURES]);
        if (!$onehot(file_exp)) begin
            stop_failed($sformatf("Data file gives no one-hot result for frame %0d", frame));
        end
        check_result("reference model vs data file", classify(frame), file_exp);
        ahb_read(RESULT_OFS, rd);
        check_result("result register", one_hot_t'(rd), file_exp);
        check_data("HRDATA upper bits at 0x000", rd >> $bits(one_hot_t), '0);
        ahb_read(COUNT_OFS, rd);
        check_count("frame count", frame_cnt_t'(rd), frames_sent);
        check_data("HRDATA upper bits at 0x004", rd >> $bits(frame_cnt_t), '0);
    endtask

    always @(posedge HCLK) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            stop_failed($sformatf("Timeout: the test did not finish in %0d cycles", CYCLE_LIMIT));
        end
    end

    initial begin
        ahb_data_t   rd;
        logic [31:0] wdata;
        HSEL        = 1'b0;
        HADDR       = '0;
        HTRANS      = 2'b00;
        HSIZE       = 3'b010;                   // Word
        HPROT       = 4'b0011;
        HWRITE      = 1'b0;
        HWDATA      = '0;
        HREADY      = 1'b1;
        beat        = '0;
        frames_sent = '0;
        $readmemh("gesture_input.txt", stim_mem);
        @(posedge HRESETn);

        check_flag("HREADYOUT", HREADYOUT, 1'b1);
        check_flag("HRESP", HRESP, 1'b0);
        ahb_read(RESULT_OFS, rd);
        check_data("result after reset", rd, '0);
        ahb_read(COUNT_OFS, rd);
        check_data("count after reset", rd, '0);

        for (int f = 0; f < N_FRAMES - 2; f++) begin
            send_frame(f, 1'b1);
            end_stream();
            frames_sent = frames_sent + 1'b1;
            repeat (3) @(negedge HCLK);
            check_frame(f);
        end

        // Unmapped offsets, ignored writes, held result
        ahb_read(32'h0000_0008, rd);
        check_data("HRDATA at 0x008", rd, '0);
        ahb_read(32'h0000_00FC, rd);
        check_data("HRDATA at 0x0FC", rd, '0);
        wdata = rand_bits(32);
        ahb_write(RESULT_OFS, wdata);
        wdata = rand_bits(32);
        ahb_write(COUNT_OFS, wdata);
        for (int r = 0; r < 3; r++) begin
            check_frame(N_FRAMES - 3);
        end

        // Two frames back to back, first result read while the second streams
        send_frame(N_FRAMES - 2, 1'b0);
        frames_sent = frames_sent + 1'b1;
        fork
            send_frame(N_FRAMES - 1, 1'b0);
            begin
                repeat (4) @(negedge HCLK);
                check_frame(N_FRAMES - 2);
            end
        join
        end_stream();
        frames_sent = frames_sent + 1'b1;
        repeat (3) @(negedge HCLK);
        check_frame(N_FRAMES - 1);
        check_flag("HRESP", HRESP, 1'b0);

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

/* tb_clock_gen.sv */
////////////////////
// Testbench clock and reset
////////////////////
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 4,
    parameter int RESET_CYCLES = 10
) (
    output logic HCLK,
    output logic HRESETn
);

    initial begin
        HCLK = 1'b0;
        forever #(PERIOD_NS / 2) HCLK = ~HCLK;
    end

    initial begin
        HRESETn = 1'b0;
        repeat (RESET_CYCLES) @(posedge HCLK);
        @(negedge HCLK);
        HRESETn = 1'b1;                 // Released away from the rising edge
    end

endmodule

/* gesture_ahb_top.sv */
////////////////////
// Gesture classifier with AHB-Lite
// result readout
////////////////////
`timescale 1ns/1ps

module gesture_ahb_top import cnn_pkg::*; #(
    parameter int N_FEATURES = 16
) (
    input  logic          HCLK,
    input  logic          HRESETn,
    input  logic          HSEL,
    input  ahb_addr_t     HADDR,
    input  logic [1:0]    HTRANS,
    input  logic [2:0]    HSIZE,
    input  logic [3:0]    HPROT,
    input  logic          HWRITE,
    input  ahb_data_t     HWDATA,
    input  logic          HREADY,
    output logic          HREADYOUT,
    output ahb_data_t     HRDATA,
    output logic          HRESP,
    input  feature_beat_t beat        // Feature stream, plain strobes
);

    score_vec_t    scores;
    class_result_t result;

    gesture_scorer #(
        .N_FEATURES (N_FEATURES)
    ) u_gesture_scorer (
        .HCLK    (HCLK),
        .HRESETn (HRESETn),
        .beat    (beat),
        .scores  (scores)
    );

    class_select u_class_select (
        .HCLK    (HCLK),
        .HRESETn (HRESETn),
        .scores  (scores),
        .result  (result)
    );

    ahb_cnn u_ahb_cnn (
        .HCLK      (HCLK),
        .HRESETn   (HRESETn),
        .HSEL      (HSEL),
        .HADDR     (HADDR),
        .HTRANS    (HTRANS),
        .HSIZE     (HSIZE),
        .HPROT     (HPROT),
        .HWRITE    (HWRITE),
        .HWDATA    (HWDATA),
        .HREADY    (HREADY),
        .result    (result),
        .HREADYOUT (HREADYOUT),
        .HRDATA    (HRDATA),
        .HRESP     (HRESP)
    );

endmodule

/* ahb_cnn.sv */
////////////////////
// AHB-Lite read-only slave with result
// register and frame counter
////////////////////
`timescale 1ns/1ps

module ahb_cnn import cnn_pkg::*; (
    input  logic          HCLK,
    input  logic          HRESETn,
    input  logic          HSEL,
    input  ahb_addr_t     HADDR,
    input  logic [1:0]    HTRANS,
    input  logic [2:0]    HSIZE,
    input  logic [3:0]    HPROT,
    input  logic          HWRITE,
    input  ahb_data_t     HWDATA,     // Writes have no effect
    input  logic          HREADY,
    input  class_result_t result,
    output logic          HREADYOUT,
    output ahb_data_t     HRDATA,
    output logic          HRESP
);

    localparam ahb_addr_t RESULT_OFS = 32'h0000_0000;
    localparam ahb_addr_t COUNT_OFS  = 32'h0000_0004;

    logic       read_en;
    logic [5:0] addr_q;         // Word address of the data phase
    one_hot_t   result_q;
    frame_cnt_t frame_cnt;

    // No wait states and never an error
    assign HREADYOUT = 1'b1;
    assign HRESP     = 1'b0;

    assign read_en = HSEL & HTRANS[1] & HREADY & ~HWRITE;

    always_ff @(posedge HCLK or negedge HRESETn) begin
        if (!HRESETn) begin
            addr_q <= '0;
        end else if (read_en) begin
            addr_q <= HADDR[7:2];
        end
    end

    always_ff @(posedge HCLK or negedge HRESETn) begin
        if (!HRESETn) begin
            result_q  <= '0;
            frame_cnt <= '0;
        end else if (result.valid) begin
            result_q  <= result.one_hot;      // Held until the next frame
            frame_cnt <= frame_cnt + 1'b1;    // Wraps
        end
    end

    // Read decode from the captured address
    always_comb begin
        case (addr_q)
            RESULT_OFS[7:2]: HRDATA = ahb_data_t'(result_q);
            COUNT_OFS[7:2]:  HRDATA = ahb_data_t'(frame_cnt);
            default:         HRDATA = '0;
        endcase
    end

endmodule

/* class_select.sv */
////////////////////
// Highest score to registered one-hot result
////////////////////
`timescale 1ns/1ps

module class_select import cnn_pkg::*; (
    input  logic          HCLK,
    input  logic          HRESETn,
    input  score_vec_t    scores,
    output class_result_t result
);

    score_t     s [4];
    logic [1:0] best;           // Index of the winning class
    one_hot_t   one_hot_q;
    logic       valid_q;

    assign s[0] = scores.class0;
    assign s[1] = scores.class1;
    assign s[2] = scores.class2;
    assign s[3] = scores.class3;

    // Strict compare so the lowest index keeps a tie
    always_comb begin
        best = 2'd0;
        for (int c = 1; c < 4; c++) begin
            if (s[c] > s[best]) begin
                best = 2'(c);
            end
        end
    end

    always_ff @(posedge HCLK or negedge HRESETn) begin
        if (!HRESETn) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= scores.valid;
        end
    end

    always_ff @(posedge HCLK) begin
        if (scores.valid) begin
            one_hot_q <= one_hot_t'(1) << best;
        end
    end

    assign result = '{valid: valid_q, one_hot: one_hot_q};

endmodule

/* gesture_scorer.sv */
////////////////////
// Feature beat counter and four class score accumulators
////////////////////
`timescale 1ns/1ps

module gesture_scorer import cnn_pkg::*; #(
    parameter int N_FEATURES = 16
) (
    input  logic          HCLK,
    input  logic          HRESETn,
    input  feature_beat_t beat,
    output score_vec_t    scores
);

    localparam int IDX_W = (N_FEATURES > 1) ? $clog2(N_FEATURES) : 1;

    typedef logic [IDX_W-1:0] beat_idx_t;

    localparam beat_idx_t LAST_IDX = beat_idx_t'(N_FEATURES - 1);

    beat_idx_t  beat_idx;       // Position of the next beat in the frame
    logic [1:0] lane;           // Class that gets weight +3
    logic       last_beat;
    score_t     feat_ext;
    score_t     acc      [4];
    score_t     acc_next [4];
    score_t     sum_q    [4];   // Final sums of the closed frame
    logic       sum_valid;

    assign lane      = 2'(beat_idx % 4);
    assign last_beat = beat.valid && (beat_idx == LAST_IDX);
    assign feat_ext  = score_t'(beat.data);  // Sign extended

    // Weight is +3 on the matching lane, -1 on the other three
    always_comb begin
        for (int c = 0; c < 4; c++) begin
            if (int'(lane) == c) begin
                acc_next[c] = acc[c] + feat_ext + feat_ext + feat_ext;
            end else begin
                acc_next[c] = acc[c] - feat_ext;
            end
        end
    end

    always_ff @(posedge HCLK or negedge HRESETn) begin
        if (!HRESETn) begin
            beat_idx <= '0;
            for (int c = 0; c < 4; c++) begin
                acc[c] <= '0;
            end
        end else if (beat.valid) begin
            if (last_beat) begin
                beat_idx <= '0;               // Next frame starts clean
                for (int c = 0; c < 4; c++) begin
                    acc[c] <= '0;
                end
            end else begin
                beat_idx <= beat_idx + 1'b1;
                for (int c = 0; c < 4; c++) begin
                    acc[c] <= acc_next[c];
                end
            end
        end
    end

    always_ff @(posedge HCLK or negedge HRESETn) begin
        if (!HRESETn) begin
            sum_valid <= 1'b0;
        end else begin
            sum_valid <= last_beat;           // One cycle pulse
        end
    end

    always_ff @(posedge HCLK) begin
        if (last_beat) begin
            for (int c = 0; c < 4; c++) begin
                sum_q[c] <= acc_next[c];      // Includes the last feature
            end
        end
    end

    assign scores = '{valid: sum_valid, class0: sum_q[0], class1: sum_q[1],
                      class2: sum_q[2], class3: sum_q[3]};

endmodule

/* cnn_pkg.sv */
////////////////////
// Shared vector types and stream structs
// for the gesture classifier
////////////////////
package cnn_pkg;

    // Meaningful widths
    typedef logic signed [7:0]  feature_t;    // One input feature
    typedef logic signed [15:0] score_t;      // Holds 32 x 128 x 3 with room
    typedef logic [3:0]         one_hot_t;    // Bit n set for class n
    typedef logic [15:0]        frame_cnt_t;  // Wraps after 65535 frames
    typedef logic [31:0]        ahb_addr_t;
    typedef logic [31:0]        ahb_data_t;

    // Input stream, one feature per strobe
    typedef struct packed {
        logic     valid;
        feature_t data;
    } feature_beat_t;

    // Frame scores, scorer to selector
    typedef struct packed {
        logic   valid;
        score_t class0;
        score_t class1;
        score_t class2;
        score_t class3;
    } score_vec_t;

    // Classification result, selector to AHB slave
    typedef struct packed {
        logic     valid;
        one_hot_t one_hot;
    } class_result_t;

endpackage
